// ==== verilog/pkt_buf_pkg.sv ====
`default_nettype none

package pkt_buf_pkg;

    // page geometry of one bank
    localparam int PAGE_W  = 11;
    localparam int PAGES   = 2048;
    localparam int SLICE_W = 3;
    localparam int SLICES  = 8;
    localparam int WORDS   = PAGES * SLICES;

    // payload and check code
    localparam int DATA_W  = 16;
    localparam int CODE_W  = 8;

    // global page address is bank index over page number
    localparam int BANK_W  = 5;
    localparam int LINK_W  = BANK_W + PAGE_W;
    localparam int ADDR_W  = PAGE_W + SLICE_W;
    // one extra bit so a full queue reads 2048
    localparam int COUNT_W = PAGE_W + 1;

    // header word fields
    localparam int PORT_W       = 4;
    localparam int PRIO_W       = 3;
    localparam int LEN_W        = 6;
    localparam int HDR_PORT_LSB = 0;
    localparam int HDR_PRIO_LSB = 4;
    localparam int HDR_LEN_LSB  = 10;

    typedef logic [PAGE_W-1:0]  page_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [CODE_W-1:0]  code_t;
    typedef logic [SLICE_W-1:0] slice_t;
    typedef logic [LINK_W-1:0]  link_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

// ==== verilog/sdp_ram.sv ====
`default_nettype none

module sdp_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    // maps onto block RAM, no reset on contents
    entry_t mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, only clocked when asked for
    // output holds its last value while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/free_page_queue.sv ====
`default_nettype none

module free_page_queue (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pop,
    input  pkt_buf_pkg::page_t    peek_offset,
    output pkt_buf_pkg::page_t    peek_page,
    input  logic                  push,
    input  pkt_buf_pkg::page_t    push_page,
    output pkt_buf_pkg::count_t   free_space
);

    import pkt_buf_pkg::*;

    // ring pointers into the free list, wrap at 2048
    page_t  head_ptr;
    page_t  tail_ptr;
    // power-up fill progress
    count_t fill_cnt;

    logic   filling;
    logic   list_we;
    page_t  list_wdata;
    page_t  list_raddr;

    assign filling = (fill_cnt != count_t'(PAGES));

    // recycled page wins over the fill sequence
    assign list_we    = push || filling;
    assign list_wdata = push ? push_page : fill_cnt[PAGE_W-1:0];

    // head entry, or further down for tail prediction
    assign list_raddr = head_ptr + peek_offset;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (filling && !push) begin
            fill_cnt <= fill_cnt + count_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail_ptr <= '0;
        end else if (list_we) begin
            tail_ptr <= tail_ptr + page_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end else if (pop) begin
            head_ptr <= head_ptr + page_t'(1);
        end
    end

    // pushes minus pops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_space <= '0;
        end else begin
            free_space <= free_space + count_t'(list_we) - count_t'(pop);
        end
    end

    // free list storage, read every cycle
    sdp_ram #(
        .entry_t (page_t),
        .DEPTH   (PAGES)
    ) u_free_list (
        .clk   (clk),
        .we    (list_we),
        .waddr (tail_ptr),
        .wdata (list_wdata),
        .re    (1'b1),
        .raddr (list_raddr),
        .rdata (peek_page)
    );

endmodule

`default_nettype wire

// ==== verilog/page_parity_encoder.sv ====
`default_nettype none

module page_parity_encoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enc_vld,
    input  pkt_buf_pkg::word_t   enc_word,
    input  pkt_buf_pkg::slice_t  enc_slice,
    input  pkt_buf_pkg::page_t   enc_page,
    input  logic                 enc_page_end,
    input  logic                 rd_en,
    input  pkt_buf_pkg::page_t   rd_page,
    output pkt_buf_pkg::code_t   rd_code
);

    import pkt_buf_pkg::*;

    // one parity bit per slice of the open page
    code_t code_acc;

    // store request, one cycle behind page end
    logic  code_we_q;
    page_t code_waddr_q;

    // slice 0 starts a fresh page
    // unwritten slices stay zero
    always_ff @(posedge clk) begin
        if (enc_vld) begin
            if (enc_slice == '0) begin
                code_acc <= '0;
            end
            code_acc[enc_slice] <= ^enc_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            code_we_q <= 1'b0;
        end else begin
            code_we_q <= enc_vld && enc_page_end;
        end
    end

    always_ff @(posedge clk) begin
        if (enc_vld && enc_page_end) begin
            code_waddr_q <= enc_page;
        end
    end

    // accumulator already holds the last slice when this writes
    sdp_ram #(
        .entry_t (code_t),
        .DEPTH   (PAGES)
    ) u_code_store (
        .clk   (clk),
        .we    (code_we_q),
        .waddr (code_waddr_q),
        .wdata (code_acc),
        .re    (rd_en),
        .raddr (rd_page),
        .rdata (rd_code)
    );

endmodule

`default_nettype wire

// ==== verilog/sram_interface.sv ====
`default_nettype none

module sram_interface #(
    parameter logic [pkt_buf_pkg::BANK_W-1:0] BANK_IDX = '0
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_xfer_data_vld,
    input  pkt_buf_pkg::word_t              wr_xfer_data,
    input  logic                            wr_end_of_packet,
    output logic                            join_request_enable,
    output logic [pkt_buf_pkg::PORT_W-1:0]  join_request_dest_port,
    output logic [pkt_buf_pkg::PRIO_W-1:0]  join_request_prior,
    output pkt_buf_pkg::link_t              join_request_head,
    output pkt_buf_pkg::link_t              join_request_tail,
    input  logic                            concatenate_enable,
    input  pkt_buf_pkg::page_t              concatenate_head,
    input  pkt_buf_pkg::link_t              concatenate_tail,
    input  logic                            rd_page_down,
    input  pkt_buf_pkg::page_t              rd_page,
    output logic                            rd_xfer_vld,
    output pkt_buf_pkg::word_t              rd_xfer_data,
    output pkt_buf_pkg::link_t              rd_next_page,
    output logic                            pop,
    output pkt_buf_pkg::page_t              peek_offset,
    input  pkt_buf_pkg::page_t              peek_page,
    output logic                            enc_vld,
    output pkt_buf_pkg::word_t              enc_word,
    output pkt_buf_pkg::slice_t             enc_slice,
    output pkt_buf_pkg::page_t              enc_page,
    output logic                            enc_page_end
);

    import pkt_buf_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_FIRST,
        WR_LATER
    } wr_state_t;

    wr_state_t wr_state;
    page_t     wr_page;
    slice_t    wr_slice;
    logic      pkt_start;
    logic      slice_last;
    logic      link_next;
    logic      jr_pending;

    // jump table write request, registered
    logic      jt_we;
    page_t     jt_waddr;
    link_t     jt_wdata;

    // read sequencer, SLICES means idle
    logic [SLICE_W:0] rd_cnt;
    logic             rd_busy;
    page_t            rd_page_q;
    addr_t            data_raddr;
    addr_t            data_waddr;

    assign pkt_start  = (wr_state == WR_IDLE) && wr_xfer_data_vld;
    assign slice_last = wr_xfer_data_vld && (wr_slice == slice_t'(SLICES - 1));
    // page full and the packet goes on
    assign link_next  = slice_last && !wr_end_of_packet;

    // header length field points at the tail entry
    assign peek_offset = pkt_start ? page_t'(wr_xfer_data[HDR_LEN_LSB +: LEN_W]) : '0;
    // take a page off the queue on each page's first word
    assign pop         = wr_xfer_data_vld && (wr_slice == '0);

    // parity encoder sees every written word
    assign enc_vld      = wr_xfer_data_vld;
    assign enc_word     = wr_xfer_data;
    assign enc_slice    = wr_slice;
    assign enc_page     = wr_page;
    assign enc_page_end = slice_last || wr_end_of_packet;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
        end else if (wr_xfer_data_vld) begin
            case (wr_state)
                WR_IDLE:  wr_state <= wr_end_of_packet ? WR_IDLE : WR_FIRST;
                WR_FIRST: begin
                    if (wr_end_of_packet) begin
                        wr_state <= WR_IDLE;
                    end else if (slice_last) begin
                        wr_state <= WR_LATER;
                    end
                end
                default:  wr_state <= wr_end_of_packet ? WR_IDLE : WR_LATER;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_slice <= '0;
        end else if (wr_xfer_data_vld) begin
            wr_slice <= wr_end_of_packet ? slice_t'(0) : wr_slice + slice_t'(1);
        end
    end

    // idle keeps tracking the queue head
    // at a page end the next page is already on peek_page
    always_ff @(posedge clk) begin
        if (wr_state == WR_IDLE || slice_last) begin
            wr_page <= peek_page;
        end
    end

    // join request, tail is on peek_page the cycle after start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            jr_pending          <= 1'b0;
            join_request_enable <= 1'b0;
        end else begin
            jr_pending          <= pkt_start;
            join_request_enable <= jr_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_start) begin
            join_request_dest_port <= wr_xfer_data[HDR_PORT_LSB +: PORT_W];
            join_request_prior     <= wr_xfer_data[HDR_PRIO_LSB +: PRIO_W];
            join_request_head      <= {BANK_IDX, wr_page};
        end
        if (jr_pending) begin
            join_request_tail <= {BANK_IDX, peek_page};
        end
    end

    // concatenate beats the in-packet link
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            jt_we <= 1'b0;
        end else begin
            jt_we <= concatenate_enable || link_next;
        end
    end

    always_ff @(posedge clk) begin
        if (concatenate_enable) begin
            jt_waddr <= concatenate_head;
            jt_wdata <= concatenate_tail;
        end else if (link_next) begin
            jt_waddr <= wr_page;
            jt_wdata <= {BANK_IDX, peek_page};
        end
    end

    // strobe fetches slice 0, counter walks 1..7
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_cnt      <= (SLICE_W + 1)'(SLICES);
            rd_xfer_vld <= 1'b0;
        end else begin
            rd_xfer_vld <= rd_page_down || rd_busy;
            if (rd_page_down) begin
                rd_cnt <= (SLICE_W + 1)'(1);
            end else if (rd_busy) begin
                rd_cnt <= rd_cnt + (SLICE_W + 1)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_page_down) begin
            rd_page_q <= rd_page;
        end
    end

    assign rd_busy    = (rd_cnt != (SLICE_W + 1)'(SLICES));
    assign data_raddr = rd_page_down ? {rd_page, slice_t'(0)}
                                     : {rd_page_q, rd_cnt[SLICE_W-1:0]};
    assign data_waddr = {wr_page, wr_slice};

    // packet words
    sdp_ram #(
        .entry_t (word_t),
        .DEPTH   (WORDS)
    ) u_data_store (
        .clk   (clk),
        .we    (wr_xfer_data_vld),
        .waddr (data_waddr),
        .wdata (wr_xfer_data),
        .re    (rd_page_down || rd_busy),
        .raddr (data_raddr),
        .rdata (rd_xfer_data)
    );

    // next-page links, read once per strobe and held
    sdp_ram #(
        .entry_t (link_t),
        .DEPTH   (PAGES)
    ) u_jump_table (
        .clk   (clk),
        .we    (jt_we),
        .waddr (jt_waddr),
        .wdata (jt_wdata),
        .re    (rd_page_down),
        .raddr (rd_page),
        .rdata (rd_next_page)
    );

endmodule

`default_nettype wire

// ==== verilog/pkt_buf_top.sv ====
`default_nettype none

module pkt_buf_top #(
    parameter logic [pkt_buf_pkg::BANK_W-1:0] BANK_IDX = '0
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_xfer_data_vld,
    input  pkt_buf_pkg::word_t              wr_xfer_data,
    input  logic                            wr_end_of_packet,
    output logic                            join_request_enable,
    output logic [pkt_buf_pkg::PORT_W-1:0]  join_request_dest_port,
    output logic [pkt_buf_pkg::PRIO_W-1:0]  join_request_prior,
    output pkt_buf_pkg::link_t              join_request_head,
    output pkt_buf_pkg::link_t              join_request_tail,
    input  logic                            concatenate_enable,
    input  pkt_buf_pkg::page_t              concatenate_head,
    input  pkt_buf_pkg::link_t              concatenate_tail,
    input  logic                            rd_page_down,
    input  pkt_buf_pkg::page_t              rd_page,
    output logic                            rd_xfer_vld,
    output pkt_buf_pkg::word_t              rd_xfer_data,
    output pkt_buf_pkg::link_t              rd_next_page,
    output pkt_buf_pkg::code_t              rd_ecc_code,
    output pkt_buf_pkg::count_t             free_space
);

    import pkt_buf_pkg::*;

    // free queue side
    logic   pop;
    page_t  peek_offset;
    page_t  peek_page;

    // encoder side
    logic   enc_vld;
    word_t  enc_word;
    slice_t enc_slice;
    page_t  enc_page;
    logic   enc_page_end;

    // a read page goes straight back onto the queue
    free_page_queue u_free_page_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .pop         (pop),
        .peek_offset (peek_offset),
        .peek_page   (peek_page),
        .push        (rd_page_down),
        .push_page   (rd_page),
        .free_space  (free_space)
    );

    page_parity_encoder u_page_parity_encoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .enc_vld      (enc_vld),
        .enc_word     (enc_word),
        .enc_slice    (enc_slice),
        .enc_page     (enc_page),
        .enc_page_end (enc_page_end),
        .rd_en        (rd_page_down),
        .rd_page      (rd_page),
        .rd_code      (rd_ecc_code)
    );

    sram_interface #(
        .BANK_IDX (BANK_IDX)
    ) u_sram_interface (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .wr_xfer_data_vld       (wr_xfer_data_vld),
        .wr_xfer_data           (wr_xfer_data),
        .wr_end_of_packet       (wr_end_of_packet),
        .join_request_enable    (join_request_enable),
        .join_request_dest_port (join_request_dest_port),
        .join_request_prior     (join_request_prior),
        .join_request_head      (join_request_head),
        .join_request_tail      (join_request_tail),
        .concatenate_enable     (concatenate_enable),
        .concatenate_head       (concatenate_head),
        .concatenate_tail       (concatenate_tail),
        .rd_page_down           (rd_page_down),
        .rd_page                (rd_page),
        .rd_xfer_vld            (rd_xfer_vld),
        .rd_xfer_data           (rd_xfer_data),
        .rd_next_page           (rd_next_page),
        .pop                    (pop),
        .peek_offset            (peek_offset),
        .peek_page              (peek_page),
        .enc_vld                (enc_vld),
        .enc_word               (enc_word),
        .enc_slice              (enc_slice),
        .enc_page               (enc_page),
        .enc_page_end           (enc_page_end)
    );

endmodule

`default_nettype wire

// ==== tests/pkt_buf_cases.svh ====
`ifndef PKT_BUF_CASES_SVH
`define PKT_BUF_CASES_SVH

// columns: op, pages, words on last page, repeats, port, priority,
//          page, expected next link or concatenate target, link checked
localparam int CASE_N = 18;

localparam case_t CASES [CASE_N] = '{
    // three packets, pages 0-2, 3-4 and 5
    '{OP_PKT, 7'd3,  4'd5, 6'd1,  4'd2,  3'd5, 11'd0, {BANK, 11'd0}, 1'b0},
    '{OP_PKT, 7'd2,  4'd8, 6'd1,  4'd9,  3'd1, 11'd0, {BANK, 11'd0}, 1'b0},
    '{OP_PKT, 7'd1,  4'd1, 6'd1,  4'd15, 3'd7, 11'd0, {BANK, 11'd0}, 1'b0},
    // tail of the first packet onto head of the second
    '{OP_CAT, 7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd2, {BANK, 11'd3}, 1'b0},
    // reads in a shuffled order, refill order follows it
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd2, {BANK, 11'd3}, 1'b1},
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd0, {BANK, 11'd1}, 1'b1},
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd1, {BANK, 11'd2}, 1'b1},
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd4, {BANK, 11'd0}, 1'b0},
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd3, {BANK, 11'd4}, 1'b1},
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd5, {BANK, 11'd0}, 1'b0},
    // large packets use up pages 6 to 2047
    '{OP_PKT, 7'd64, 4'd8, 6'd31, 4'd0,  3'd0, 11'd0, {BANK, 11'd0}, 1'b0},
    '{OP_PKT, 7'd58, 4'd3, 6'd1,  4'd6,  3'd3, 11'd0, {BANK, 11'd0}, 1'b0},
    // queue wrapped, recycled pages 2 0 1
    '{OP_PKT, 7'd3,  4'd8, 6'd1,  4'd12, 3'd2, 11'd0, {BANK, 11'd0}, 1'b0},
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd2, {BANK, 11'd0}, 1'b1},
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd0, {BANK, 11'd1}, 1'b1},
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd1, {BANK, 11'd0}, 1'b0},
    // first page of the large packets, and a tail with a short page
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd6, {BANK, 11'd7}, 1'b1},
    '{OP_RD,  7'd0,  4'd0, 6'd0,  4'd0,  3'd0, 11'd2047, {BANK, 11'd0}, 1'b0}
};

`endif

// ==== tests/pkt_buf_tb.sv ====
`default_nettype none

module pkt_buf_tb;

    import pkt_buf_pkg::*;

    localparam logic [BANK_W-1:0] BANK = 5'd19;

    typedef enum logic [1:0] {
        OP_PKT,
        OP_CAT,
        OP_RD
    } op_t;

    // one table row whose used fields depend on op
    typedef struct packed {
        op_t               op;
        logic [6:0]        pages;
        logic [3:0]        last;
        logic [5:0]        reps;
        logic [PORT_W-1:0] port;
        logic [PRIO_W-1:0] prio;
        page_t             page;
        link_t             link;
        logic              chk;
    } case_t;

    `include "pkt_buf_cases.svh"

    logic              clk;
    logic              rst_n;
    logic              wr_xfer_data_vld;
    word_t             wr_xfer_data;
    logic              wr_end_of_packet;
    logic              join_request_enable;
    logic [PORT_W-1:0] join_request_dest_port;
    logic [PRIO_W-1:0] join_request_prior;
    link_t             join_request_head;
    link_t             join_request_tail;
    logic              concatenate_enable;
    page_t             concatenate_head;
    link_t             concatenate_tail;
    logic              rd_page_down;
    page_t             rd_page;
    logic              rd_xfer_vld;
    word_t             rd_xfer_data;
    link_t             rd_next_page;
    code_t             rd_ecc_code;
    count_t            free_space;

    // reference model of free queue, stored words and written slices
    page_t             free_q [$];
    word_t             model_mem [WORDS];
    logic [SLICES-1:0] written [PAGES];
    logic [15:0]       lfsr;
    int                errors;
    int                checks;

    pkt_buf_top #(
        .BANK_IDX (BANK)
    ) DUT (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .wr_xfer_data_vld       (wr_xfer_data_vld),
        .wr_xfer_data           (wr_xfer_data),
        .wr_end_of_packet       (wr_end_of_packet),
        .join_request_enable    (join_request_enable),
        .join_request_dest_port (join_request_dest_port),
        .join_request_prior     (join_request_prior),
        .join_request_head      (join_request_head),
        .join_request_tail      (join_request_tail),
        .concatenate_enable     (concatenate_enable),
        .concatenate_head       (concatenate_head),
        .concatenate_tail       (concatenate_tail),
        .rd_page_down           (rd_page_down),
        .rd_page                (rd_page),
        .rd_xfer_vld            (rd_xfer_vld),
        .rd_xfer_data           (rd_xfer_data),
        .rd_next_page           (rd_next_page),
        .rd_ecc_code            (rd_ecc_code),
        .free_space             (free_space)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per payload bit
    task automatic make_body_word(output word_t w);
        int b;
        for (b = 0; b < DATA_W; b++) begin
            w[b] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_link(input string name, input link_t exp, input link_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_code(input string name, input code_t exp, input code_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_port(input string name, input logic [PORT_W-1:0] exp,
                              input logic [PORT_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_prio(input string name, input logic [PRIO_W-1:0] exp,
                              input logic [PRIO_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // header first and lfsr words after it
    // three idle cycles close the packet
    task automatic send_packet(input case_t c);
        int    nwords;
        int    i;
        int    slice;
        int    seen;
        page_t pg;
        word_t w;
        link_t exp_head;
        link_t exp_tail;
        nwords   = (int'(c.pages) - 1) * SLICES + int'(c.last);
        exp_head = {BANK, free_q[0]};
        exp_tail = {BANK, free_q[c.pages - 1]};
        seen     = 0;
        pg       = '0;
        for (i = 0; i < nwords + 3; i++) begin
            @(posedge clk);
            #1;
            // request expected two edges after word 0 goes out
            if (join_request_enable) begin
                seen++;
                if (i != 2) begin
                    errors++;
                    $display("join request came at cycle %0d of the packet, not at 2", i);
                end else begin
                    check_link("join head", exp_head, join_request_head);
                    check_link("join tail", exp_tail, join_request_tail);
                    check_port("join port", c.port, join_request_dest_port);
                    check_prio("join priority", c.prio, join_request_prior);
                end
            end
            if (i < nwords) begin
                slice = i % SLICES;
                if (slice == 0) begin
                    pg = free_q.pop_front();
                    written[pg] = '0;
                end
                if (i == 0) begin
                    w = word_t'({6'(c.pages - 7'd1), 3'b000, c.prio, c.port});
                end else begin
                    make_body_word(w);
                end
                model_mem[int'(pg) * SLICES + slice] = w;
                written[pg][slice] = 1'b1;
                wr_xfer_data_vld = 1'b1;
                wr_xfer_data     = w;
                wr_end_of_packet = (i == nwords - 1);
            end else begin
                wr_xfer_data_vld = 1'b0;
                wr_xfer_data     = '0;
                wr_end_of_packet = 1'b0;
            end
        end
        if (seen != 1) begin
            errors++;
            $display("join request seen %0d times for one packet", seen);
        end
        check_count("free space after packet", count_t'(free_q.size()), free_space);
    endtask

    // tail page of one packet gets the head of another
    task automatic join_pages(input case_t c);
        @(posedge clk);
        #1;
        concatenate_enable = 1'b1;
        concatenate_head   = c.page;
        concatenate_tail   = c.link;
        @(posedge clk);
        #1;
        concatenate_enable = 1'b0;
    endtask

    task automatic read_page(input case_t c);
        int    k;
        int    wait_cnt;
        code_t exp_code;
        for (k = 0; k < SLICES; k++) begin
            exp_code[k] = written[c.page][k] ? ^model_mem[int'(c.page) * SLICES + k] : 1'b0;
        end
        @(posedge clk);
        #1;
        rd_page_down = 1'b1;
        rd_page      = c.page;
        @(posedge clk);
        #1;
        rd_page_down = 1'b0;
        wait_cnt     = 0;
        while (!rd_xfer_vld && wait_cnt < 8) begin
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        if (!rd_xfer_vld) begin
            errors++;
            $display("timeout waiting for rd_xfer_vld on page %0d", c.page);
        end else begin
            if (wait_cnt != 0) begin
                errors++;
                $display("rd_xfer_vld for page %0d came %0d cycles late", c.page, wait_cnt);
            end
            check_code($sformatf("code of page %0d", c.page), exp_code, rd_ecc_code);
            if (c.chk) begin
                check_link($sformatf("next of page %0d", c.page), c.link, rd_next_page);
            end
            for (k = 0; k < SLICES; k++) begin
                if (k > 0) begin
                    @(posedge clk);
                    #1;
                end
                if (!rd_xfer_vld) begin
                    errors++;
                    $display("rd_xfer_vld dropped at slice %0d of page %0d", k, c.page);
                end else if (written[c.page][k]) begin
                    check_word($sformatf("page %0d slice %0d", c.page, k),
                               model_mem[int'(c.page) * SLICES + k], rd_xfer_data);
                end
            end
            @(posedge clk);
            #1;
            if (rd_xfer_vld) begin
                errors++;
                $display("rd_xfer_vld stayed high past eight slices of page %0d", c.page);
            end
        end
        // read page goes to the back of the queue
        free_q.push_back(c.page);
        check_count("free space after read", count_t'(free_q.size()), free_space);
    endtask

    initial begin
        int idx;
        int r;
        int wait_cnt;
        rst_n              = 1'b0;
        wr_xfer_data_vld   = 1'b0;
        wr_xfer_data       = '0;
        wr_end_of_packet   = 1'b0;
        concatenate_enable = 1'b0;
        concatenate_head   = '0;
        concatenate_tail   = '0;
        rd_page_down       = 1'b0;
        rd_page            = '0;
        lfsr               = 16'd54259;
        errors             = 0;
        checks             = 0;
        // power-up fill order
        for (idx = 0; idx < PAGES; idx++) begin
            free_q.push_back(page_t'(idx));
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // no request and no read data right out of reset
        if (join_request_enable !== 1'b0 || rd_xfer_vld !== 1'b0) begin
            errors++;
            $display("join_request_enable or rd_xfer_vld not low after reset");
        end
        wait_cnt = 0;
        while (free_space !== count_t'(PAGES) && wait_cnt < 2100) begin
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        if (free_space !== count_t'(PAGES)) begin
            errors++;
            $display("timeout waiting for the free queue to fill, at %0d", free_space);
        end
        for (idx = 0; idx < CASE_N; idx++) begin
            case (CASES[idx].op)
                OP_PKT: begin
                    for (r = 0; r < int'(CASES[idx].reps); r++) begin
                        send_packet(CASES[idx]);
                    end
                end
                OP_CAT:  join_pages(CASES[idx]);
                default: read_page(CASES[idx]);
            endcase
        end
        repeat (4) @(posedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tests
verilog/pkt_buf_pkg.sv
verilog/sdp_ram.sv
verilog/free_page_queue.sv
verilog/page_parity_encoder.sv
verilog/sram_interface.sv
verilog/pkt_buf_top.sv
tests/pkt_buf_tb.sv

// ==== Bender.yml ====
package:
  name: pkt_buf

sources:
  - files:
      - verilog/pkt_buf_pkg.sv
      - verilog/sdp_ram.sv
      - verilog/free_page_queue.sv
      - verilog/page_parity_encoder.sv
      - verilog/sram_interface.sv
      - verilog/pkt_buf_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/pkt_buf_tb.sv
